//--- files.f
streamer_pkg.sv
streamer_fsm.sv
streamer_addr_gen.sv
streamer_tcdm_port.sv
streamer_load_path.sv
streamer_top.sv
tb_streamer_properties.sv
tb_streamer.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+1000
TOP       ?= tb_streamer
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_streamer.sv
module tb_streamer;

  import streamer_pkg::*;

  localparam int unsigned MEM_WORDS  = 256;
  localparam int unsigned WAIT_LIMIT = 2000; // cycles allowed for one job

  logic            clk_i;
  logic            arst_n_i;
  streamer_ctrl_t  ctrl_i;
  streamer_flags_t flags_o;
  tcdm_req_t       tcdm_req_o;
  tcdm_rsp_t       tcdm_rsp_i;
  stream_t         feat_o;
  stream_t         weight_o;
  stream_t         norm_o;
  stream_t         streamin_o;
  logic            feat_ready_i;
  logic            weight_ready_i;
  logic            norm_ready_i;
  logic            streamin_ready_i;
  stream_t         conv_i;
  logic            conv_ready_o;

  streamer_top dut (.*);

  logic [31:0]       lfsr_q = 32'h23eedcf6;
  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic              full_gnt;   // grant every cycle
  logic              bp_mode;    // random ready on the load streams
  int                applied;    // logged writes already in mem
  int                n_mismatch = 0;
  int                n_other    = 0;

  // store stream source
  logic [DATA_W-1:0] conv_words [$];
  int                conv_base;
  int                conv_raised;

  // filled by the monitor at each rising edge
  logic                    rd_pend_q = 1'b0;
  logic [7:0]              rd_idx_q  = '0;
  logic [ADDR_W-1:0]       wr_addr_q [$];
  logic [DATA_W-1:0]       wr_data_q [$];
  logic [DATA_W+1:0]       taken_q [$];   // {stream index, word}
  int                      valid_cnt [N_LD_STREAMS] = '{default: 0};
  int                      done_cnt = 0;
  int                      conv_cnt = 0;
  stream_t                 ld_o [N_LD_STREAMS];
  logic [N_LD_STREAMS-1:0] ld_rdy;

  assign ld_o[0] = feat_o;
  assign ld_o[1] = weight_o;
  assign ld_o[2] = norm_o;
  assign ld_o[3] = streamin_o;
  assign ld_rdy  = {streamin_ready_i, norm_ready_i, weight_ready_i, feat_ready_i};

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    rd_pend_q <= tcdm_req_o.req & tcdm_rsp_i.gnt & tcdm_req_o.wen;
    rd_idx_q  <= tcdm_req_o.addr[9:2]; // word index into the model
    if (tcdm_req_o.req && tcdm_rsp_i.gnt && !tcdm_req_o.wen) begin
      wr_addr_q.push_back(tcdm_req_o.addr);
      wr_data_q.push_back(tcdm_req_o.wdata);
    end
    for (int i = 0; i < N_LD_STREAMS; i++) begin
      if (ld_o[i].valid) begin
        valid_cnt[i] <= valid_cnt[i] + 1;
        if (ld_rdy[i]) taken_q.push_back({2'(i), ld_o[i].data});
      end
    end
    if (flags_o.done) done_cnt <= done_cnt + 1;
    if (conv_i.valid && conv_ready_o) conv_cnt <= conv_cnt + 1;
  end

  // galois lfsr stepped once per bit
  function automatic logic next_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  task automatic check_val(input string name, input logic [DATA_W+1:0] got,
                           input logic [DATA_W+1:0] exp);
    assert (got === exp) else begin
      n_mismatch++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    assert (got == exp) else begin
      n_other++;
      $display("wrong number of %s at %0t: saw %0d instead of %0d", what, $time, got, exp);
    end
  endtask

  // drives one cycle of the memory model and the stream sources on the falling edge
  task automatic tick();
    int idx;
    @(negedge clk_i);
    while (applied < wr_addr_q.size()) begin
      mem[wr_addr_q[applied][9:2]] = wr_data_q[applied];
      applied++;
    end
    tcdm_rsp_i.gnt     = full_gnt ? 1'b1 : next_bit();
    tcdm_rsp_i.r_valid = rd_pend_q;
    tcdm_rsp_i.r_data  = rd_pend_q ? mem[rd_idx_q] : '0;
    feat_ready_i       = bp_mode ? next_bit() : 1'b1;
    weight_ready_i     = bp_mode ? next_bit() : 1'b1;
    norm_ready_i       = bp_mode ? next_bit() : 1'b1;
    streamin_ready_i   = bp_mode ? next_bit() : 1'b1;
    idx = conv_cnt - conv_base;
    if (!conv_i.valid || conv_cnt != conv_raised) begin // an offered word holds until taken
      conv_i = '0;
      if (idx < conv_words.size() && next_bit()) begin
        conv_i.valid = 1'b1;
        conv_i.data  = conv_words[idx];
        conv_raised  = conv_cnt;
      end
    end
  endtask

  task automatic start_job(input logic st, input ld_sel_e sel, input logic [ADDR_W-1:0] base,
                           input logic [ADDR_W-1:0] stride, input logic [LEN_W-1:0] len);
    ctrl_i.start         = 1'b1;
    ctrl_i.ld_st         = st;
    ctrl_i.ld_sel        = sel;
    ctrl_i.cfg.base_addr = base;
    ctrl_i.cfg.stride    = stride;
    ctrl_i.cfg.tot_len   = len;
    tick();
    ctrl_i.start = 1'b0;
  endtask

  task automatic wait_done(input string what, input int done0);
    int n;
    n = 0;
    while (done_cnt == done0 && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    assert (done_cnt != done0) else begin
      n_other++;
      $display("timeout at %0t: no done pulse in %s", $time, what);
    end
    repeat (4) tick(); // room for a second done pulse
  endtask

  task automatic check_reset_state();
    check_val("flags_o.busy", 34'(flags_o.busy), 34'(0));
    check_val("flags_o.done", 34'(flags_o.done), 34'(0));
    check_val("tcdm_req_o.req", 34'(tcdm_req_o.req), 34'(0));
    check_val("conv_ready_o", 34'(conv_ready_o), 34'(0));
    for (int i = 0; i < N_LD_STREAMS; i++) begin
      check_val($sformatf("stream %0d valid", i), 34'(ld_o[i].valid), 34'(0));
    end
  endtask

  task automatic run_load(input string name, input ld_sel_e sel, input logic [ADDR_W-1:0] base,
                          input logic [ADDR_W-1:0] stride, input logic [LEN_W-1:0] len,
                          input logic poke_busy);
    int                t0;
    int                d0;
    int                n;
    int                v0 [N_LD_STREAMS];
    logic [ADDR_W-1:0] a;
    t0 = taken_q.size();
    d0 = done_cnt;
    v0 = valid_cnt;
    n  = (len == 0) ? 1 : int'(len);
    start_job(1'b0, sel, base, stride, len);
    if (poke_busy) begin
      check_val("flags_o.busy", 34'(flags_o.busy), 34'(1));
      // a second job that must be dropped
      start_job(1'b0, LD_WEIGHT, 16'h0000, 16'h0004, 16'd3);
    end
    wait_done(name, d0);
    check_count("done pulses", done_cnt - d0, 1);
    check_count("loaded words", taken_q.size() - t0, n);
    check_val("flags_o.busy", 34'(flags_o.busy), 34'(0));
    a = base;
    for (int k = 0; k < n && t0 + k < taken_q.size(); k++) begin
      check_val($sformatf("%s stream/word %0d", name, k), taken_q[t0 + k], {sel, mem[a[9:2]]});
      a = a + stride;
    end
    for (int i = 0; i < N_LD_STREAMS; i++) begin
      if (i != int'(sel)) check_count("valid cycles on an unselected stream",
                                      valid_cnt[i] - v0[i], 0);
    end
  endtask

  task automatic run_store(input logic [ADDR_W-1:0] base, input logic [ADDR_W-1:0] stride);
    logic [DATA_W-1:0] img [MEM_WORDS];
    int                w0;
    int                d0;
    logic [ADDR_W-1:0] a;
    conv_words.delete();
    conv_base = conv_cnt;
    for (int k = 0; k < 8; k++) conv_words.push_back(rand_bits(32));
    img = mem;
    w0  = wr_addr_q.size();
    d0  = done_cnt;
    a   = base;
    for (int k = 0; k < 8; k++) begin
      img[a[9:2]] = conv_words[k];
      a = a + stride;
    end
    start_job(1'b1, LD_FEAT, base, stride, 16'd8);
    wait_done("store", d0);
    check_count("done pulses", done_cnt - d0, 1);
    check_count("granted writes", wr_addr_q.size() - w0, 8);
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_val($sformatf("mem[%0d]", i), 34'(mem[i]), 34'(img[i]));
    end
  endtask

  initial begin
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    ctrl_i           = '0;
    tcdm_rsp_i       = '0;
    conv_i           = '0;
    feat_ready_i     = 1'b1;
    weight_ready_i   = 1'b1;
    norm_ready_i     = 1'b1;
    streamin_ready_i = 1'b1;
    full_gnt         = 1'b1;
    bp_mode          = 1'b0;
    applied          = 0;
    conv_base        = 0;
    conv_raised      = -1;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = rand_bits(32);
    repeat (16) tick();
    arst_n_i = 1'b1;
    tick();
    check_reset_state();

    run_load("feat load", LD_FEAT, 16'h0010, 16'h0004, 16'd8, 1'b0);
    run_load("weight load", LD_WEIGHT, 16'(rand_bits(6) << 2), 16'(rand_bits(3) << 2),
             16'(rand_bits(4) + 1), 1'b0);
    run_load("norm load", LD_NORM, 16'(rand_bits(6) << 2), 16'(rand_bits(3) << 2),
             16'(rand_bits(4) + 1), 1'b0);
    run_load("streamin load", LD_STREAMIN, 16'(rand_bits(6) << 2), 16'(rand_bits(3) << 2),
             16'(rand_bits(4) + 1), 1'b0);

    full_gnt = 1'b0;
    bp_mode  = 1'b1;
    run_load("load with back-pressure", LD_FEAT, 16'h0100, 16'h0008, 16'd24, 1'b0);
    bp_mode  = 1'b0;
    run_store(16'h0200, 16'h000c);

    full_gnt = 1'b1;
    run_load("start while busy", LD_NORM, 16'h0040, 16'h0004, 16'd6, 1'b1);

    $display("errors: %0d mismatches, %0d other failures, %0d property failures",
             n_mismatch, n_other,
             dut.i_props.req_fail + dut.i_props.sel_fail + dut.i_props.done_fail);
    if (n_mismatch + n_other + dut.i_props.req_fail + dut.i_props.sel_fail
        + dut.i_props.done_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb_streamer_properties.sv
module tb_streamer_properties (
  input logic                                  clk_i,
  input logic                                  arst_n_i,
  input streamer_pkg::streamer_flags_t         flags_i,
  input streamer_pkg::tcdm_req_t               tcdm_req_i,
  input streamer_pkg::tcdm_rsp_t               tcdm_rsp_i,
  input logic [streamer_pkg::N_LD_STREAMS-1:0] ld_valid_i
);

  int req_fail  = 0;
  int sel_fail  = 0;
  int done_fail = 0;

  // a waiting request keeps address, direction and data until its grant
  req_stable_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      tcdm_req_i.req && !tcdm_rsp_i.gnt |=>
        tcdm_req_i.req && $stable(tcdm_req_i.addr) && $stable(tcdm_req_i.wen)
        && $stable(tcdm_req_i.wdata)
  ) else begin
    req_fail = req_fail + 1;
    $error("memory request dropped or changed before its grant");
  end

  one_stream_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(ld_valid_i)
  ) else begin
    sel_fail = sel_fail + 1;
    $error("more than one load stream valid");
  end

  done_pulse_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) flags_i.done |=> !flags_i.done
  ) else begin
    done_fail = done_fail + 1;
    $error("done held for more than one cycle");
  end

endmodule

bind streamer_top tb_streamer_properties i_props (
  .clk_i      ( clk_i      ),
  .arst_n_i   ( arst_n_i   ),
  .flags_i    ( flags_o    ),
  .tcdm_req_i ( tcdm_req_o ),
  .tcdm_rsp_i ( tcdm_rsp_i ),
  .ld_valid_i ( {streamin_o.valid, norm_o.valid, weight_o.valid, feat_o.valid} )
);

//--- streamer_top.sv
module streamer_top (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // control
  input  streamer_pkg::streamer_ctrl_t  ctrl_i,
  output streamer_pkg::streamer_flags_t flags_o,
  // memory port
  output streamer_pkg::tcdm_req_t       tcdm_req_o,
  input  streamer_pkg::tcdm_rsp_t       tcdm_rsp_i,
  // load streams
  output streamer_pkg::stream_t         feat_o,
  input  logic                          feat_ready_i,
  output streamer_pkg::stream_t         weight_o,
  input  logic                          weight_ready_i,
  output streamer_pkg::stream_t         norm_o,
  input  logic                          norm_ready_i,
  output streamer_pkg::stream_t         streamin_o,
  input  logic                          streamin_ready_i,
  // store stream
  input  streamer_pkg::stream_t         conv_i,
  output logic                          conv_ready_o
);

  import streamer_pkg::*;

  logic              agen_start;
  agen_cfg_t         agen_cfg;
  logic              run;
  logic              ld_st;
  ld_sel_e           ld_sel;
  logic [ADDR_W-1:0] addr;
  logic              addr_valid;
  logic              addr_last;
  logic              issue;        // one per granted request
  logic              last_issued;
  logic              credit_ok;
  logic              load_idle;

  streamer_fsm i_fsm (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .ctrl_i        ( ctrl_i      ),
    .last_issued_i ( last_issued ),
    .load_idle_i   ( load_idle   ),
    .agen_start_o  ( agen_start  ),
    .agen_cfg_o    ( agen_cfg    ),
    .run_o         ( run         ),
    .ld_st_o       ( ld_st       ),
    .ld_sel_o      ( ld_sel      ),
    .flags_o       ( flags_o     )
  );

  streamer_addr_gen i_addr_gen (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .start_i      ( agen_start ),
    .cfg_i        ( agen_cfg   ),
    .issue_i      ( issue      ),
    .addr_o       ( addr       ),
    .addr_valid_o ( addr_valid ),
    .addr_last_o  ( addr_last  )
  );

  streamer_tcdm_port i_tcdm_port (
    .run_i         ( run          ),
    .ld_st_i       ( ld_st        ),
    .addr_i        ( addr         ),
    .addr_valid_i  ( addr_valid   ),
    .addr_last_i   ( addr_last    ),
    .credit_ok_i   ( credit_ok    ),
    .conv_i        ( conv_i       ),
    .tcdm_rsp_i    ( tcdm_rsp_i   ),
    .tcdm_req_o    ( tcdm_req_o   ),
    .conv_ready_o  ( conv_ready_o ),
    .issue_o       ( issue        ),
    .last_issued_o ( last_issued  )
  );

  streamer_load_path i_load_path (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .ld_sel_i         ( ld_sel           ),
    .issue_i          ( issue            ),
    .ld_st_i          ( ld_st            ),
    .tcdm_rsp_i       ( tcdm_rsp_i       ),
    .feat_ready_i     ( feat_ready_i     ),
    .weight_ready_i   ( weight_ready_i   ),
    .norm_ready_i     ( norm_ready_i     ),
    .streamin_ready_i ( streamin_ready_i ),
    .feat_o           ( feat_o           ),
    .weight_o         ( weight_o         ),
    .norm_o           ( norm_o           ),
    .streamin_o       ( streamin_o       ),
    .credit_ok_o      ( credit_ok        ),
    .load_idle_o      ( load_idle        )
  );

endmodule

//--- streamer_load_path.sv
module streamer_load_path (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  streamer_pkg::ld_sel_e   ld_sel_i,
  input  logic                    issue_i,
  input  logic                    ld_st_i,
  input  streamer_pkg::tcdm_rsp_t tcdm_rsp_i,
  input  logic                    feat_ready_i,
  input  logic                    weight_ready_i,
  input  logic                    norm_ready_i,
  input  logic                    streamin_ready_i,
  output streamer_pkg::stream_t   feat_o,
  output streamer_pkg::stream_t   weight_o,
  output streamer_pkg::stream_t   norm_o,
  output streamer_pkg::stream_t   streamin_o,
  output logic                    credit_ok_o,
  output logic                    load_idle_o
);

  import streamer_pkg::*;

  logic [RD_CNT_W-1:0] out_cnt_q;   // granted reads not yet answered
  logic [RD_CNT_W-1:0] fill_q;      // fifo occupancy
  logic [RD_PTR_W-1:0] wr_ptr_q;
  logic [RD_PTR_W-1:0] rd_ptr_q;
  logic [DATA_W-1:0]   fifo_q [RD_FIFO_DEPTH];
  logic [RD_CNT_W:0]   inflight;

  logic rd_issue;
  logic push;
  logic pop;
  logic head_valid;

  logic [N_LD_STREAMS-1:0] ld_ready;
  stream_t                 ld_s [N_LD_STREAMS];

  assign rd_issue   = issue_i & ~ld_st_i;
  assign push       = tcdm_rsp_i.r_valid;
  assign head_valid = (fill_q != '0);
  assign pop        = head_valid & ld_ready[ld_sel_i];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_cnt_q <= '0;
      fill_q    <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end else begin
      case ({rd_issue, push})
        2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
        2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
        default: out_cnt_q <= out_cnt_q;
      endcase
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // credit keeps a free slot for every read in flight, so push never overflows
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= tcdm_rsp_i.r_data;
    end
  end

  assign inflight    = (RD_CNT_W+1)'(out_cnt_q) + (RD_CNT_W+1)'(fill_q);
  assign credit_ok_o = (inflight < (RD_CNT_W+1)'(RD_FIFO_DEPTH));
  assign load_idle_o = (out_cnt_q == '0) & (fill_q == '0);

  // demux of the fifo head, only the selected stream sees valid
  assign ld_ready = {streamin_ready_i, norm_ready_i, weight_ready_i, feat_ready_i};

  always_comb begin
    for (int i = 0; i < N_LD_STREAMS; i++) begin
      ld_s[i].valid = head_valid & (int'(ld_sel_i) == i);
      ld_s[i].data  = fifo_q[rd_ptr_q];
    end
  end

  assign feat_o     = ld_s[LD_FEAT];
  assign weight_o   = ld_s[LD_WEIGHT];
  assign norm_o     = ld_s[LD_NORM];
  assign streamin_o = ld_s[LD_STREAMIN];

endmodule

//--- streamer_tcdm_port.sv
module streamer_tcdm_port (
  input  logic                            run_i,
  input  logic                            ld_st_i,
  input  logic [streamer_pkg::ADDR_W-1:0] addr_i,
  input  logic                            addr_valid_i,
  input  logic                            addr_last_i,
  input  logic                            credit_ok_i,
  input  streamer_pkg::stream_t           conv_i,
  input  streamer_pkg::tcdm_rsp_t         tcdm_rsp_i,
  output streamer_pkg::tcdm_req_t         tcdm_req_o,
  output logic                            conv_ready_o,
  output logic                            issue_o,
  output logic                            last_issued_o
);

  import streamer_pkg::*;

  logic rd_req;
  logic wr_req;
  logic req;

  // a read needs room for its response, a write needs a conv word
  assign rd_req = run_i & addr_valid_i & ~ld_st_i & credit_ok_i;
  assign wr_req = run_i & addr_valid_i & ld_st_i & conv_i.valid;
  assign req    = rd_req | wr_req;

  // inputs hold while req waits for gnt, so the request stays stable
  always_comb begin
    tcdm_req_o.req   = req;
    tcdm_req_o.wen   = ~ld_st_i;   // high for reads
    tcdm_req_o.addr  = addr_i;
    tcdm_req_o.wdata = '0;
    if (ld_st_i) begin
      tcdm_req_o.wdata = conv_i.data;
    end
  end

  // conv word is consumed by the granted write
  assign conv_ready_o = wr_req & tcdm_rsp_i.gnt;

  assign issue_o       = req & tcdm_rsp_i.gnt;
  assign last_issued_o = issue_o & addr_last_i; // closes the request phase of the job

endmodule

//--- streamer_addr_gen.sv
module streamer_addr_gen (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            start_i,
  input  streamer_pkg::agen_cfg_t         cfg_i,
  input  logic                            issue_i,
  output logic [streamer_pkg::ADDR_W-1:0] addr_o,
  output logic                            addr_valid_o,
  output logic                            addr_last_o
);

  import streamer_pkg::*;

  logic [LEN_W-1:0]  left_q;   // words still to issue
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] stride_q;
  logic              step;

  assign step = issue_i & (left_q != '0);

  // word counter
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      left_q <= '0;
    end else if (start_i) begin
      if (cfg_i.tot_len == '0) begin
        left_q <= LEN_W'(1); // zero length runs a single word
      end else begin
        left_q <= cfg_i.tot_len;
      end
    end else if (step) begin
      left_q <= left_q - 1'b1;
    end
  end

  // address accumulator
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= cfg_i.base_addr;
      stride_q <= cfg_i.stride;
    end else if (step) begin
      addr_q <= addr_q + stride_q; // wraps within the byte address space
    end
  end

  assign addr_o       = addr_q;
  assign addr_valid_o = (left_q != '0);
  assign addr_last_o  = (left_q == LEN_W'(1));

endmodule

//--- streamer_fsm.sv
module streamer_fsm (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  streamer_pkg::streamer_ctrl_t  ctrl_i,
  input  logic                          last_issued_i,
  input  logic                          load_idle_i,
  output logic                          agen_start_o,
  output streamer_pkg::agen_cfg_t       agen_cfg_o,
  output logic                          run_o,
  output logic                          ld_st_o,
  output streamer_pkg::ld_sel_e         ld_sel_o,
  output streamer_pkg::streamer_flags_t flags_o
);

  import streamer_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RUN,   // requests may issue
    DRAIN  // load only, waits for the response fifo to empty
  } state_e;

  state_e  state_q, state_d;
  logic    start_ok;
  logic    ld_st_q;
  ld_sel_e ld_sel_q;
  logic    store_done_q;

  assign start_ok = ctrl_i.start & (state_q == IDLE); // starts while busy are dropped

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_ok) state_d = RUN;
      end
      RUN: begin
        if (last_issued_i) state_d = ld_st_q ? IDLE : DRAIN;
      end
      DRAIN: begin
        if (load_idle_i) state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= IDLE;
      ld_st_q      <= 1'b0;
      ld_sel_q     <= LD_FEAT;
      store_done_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      store_done_q <= (state_q == RUN) & last_issued_i & ld_st_q;
      if (start_ok) begin
        ld_st_q  <= ctrl_i.ld_st; // job kind held for the whole job
        ld_sel_q <= ctrl_i.ld_sel;
      end
    end
  end

  // addr_gen captures the address config itself on the start pulse
  assign agen_start_o = start_ok;
  assign agen_cfg_o   = ctrl_i.cfg;

  assign run_o    = (state_q == RUN);
  assign ld_st_o  = ld_st_q;
  assign ld_sel_o = ld_sel_q;

  // load done is seen in the first cycle with the fifo empty
  assign flags_o.busy = (state_q != IDLE);
  assign flags_o.done = store_done_q | ((state_q == DRAIN) & load_idle_i);

endmodule

//--- streamer_pkg.sv
package streamer_pkg;

  // widths and depths
  localparam int unsigned DATA_W        = 32; // memory and stream word
  localparam int unsigned ADDR_W        = 16; // byte address
  localparam int unsigned LEN_W         = 16; // job length in words
  localparam int unsigned RD_FIFO_DEPTH = 4;  // keep a power of two, pointers wrap naturally
  localparam int unsigned N_LD_STREAMS  = 4;

  localparam int unsigned RD_PTR_W = $clog2(RD_FIFO_DEPTH);
  localparam int unsigned RD_CNT_W = $clog2(RD_FIFO_DEPTH + 1); // holds 0..RD_FIFO_DEPTH

  // which outgoing stream receives the loaded words
  typedef enum logic [1:0] {
    LD_FEAT     = 2'd0,
    LD_WEIGHT   = 2'd1,
    LD_NORM     = 2'd2,
    LD_STREAMIN = 2'd3
  } ld_sel_e;

  // strided run of word addresses
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;
    logic [ADDR_W-1:0] stride;    // in bytes
    logic [LEN_W-1:0]  tot_len;   // 0 behaves as 1
  } agen_cfg_t;

  typedef struct packed {
    logic      start;  // one-cycle pulse
    logic      ld_st;  // 0 load, 1 store
    ld_sel_e   ld_sel;
    agen_cfg_t cfg;
  } streamer_ctrl_t;

  typedef struct packed {
    logic busy;
    logic done;
  } streamer_flags_t;

  // memory port request, wen follows the hci convention: 1 read, 0 write
  typedef struct packed {
    logic              req;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } tcdm_req_t;

  // r_valid comes exactly one cycle after a granted read
  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
  } tcdm_rsp_t;

  // ready travels on its own wire, against the stream direction
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } stream_t;

endpackage
